// File: mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int ADDR_W    = 32;   // Byte address
    localparam int WORD_W    = 32;   // Data word
    localparam int LANE_W    = 8;    // One byte lane
    localparam int NUM_LANES = 4;    // Lanes per word

    // Start of memory mapped I/O, never backed by RAM
    localparam logic [ADDR_W-1:0] IO_BASE = 32'h1100_0000;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [NUM_LANES-1:0] lane_en_t;   // One bit per byte lane

endpackage

`default_nettype wire

// File: mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE,   // lb / lbu / sb
        SIZE_HALF,   // lh / lhu / sh
        SIZE_WORD    // lw / sw
    } access_size_t;

    typedef enum logic [1:0] {
        REGION_RAM,  // Backed by the word array
        REGION_IO,   // At or above IO_BASE
        REGION_BAD   // Misaligned or past end of RAM
    } region_t;

    // Lowest lane touched by an access
    // Halves sit on lane 0 or 2 only
    function automatic logic [1:0] lane_base(access_size_t size, logic [1:0] offset);
        case (size)
            SIZE_BYTE: lane_base = offset;
            SIZE_HALF: lane_base = {offset[1], 1'b0};
            default:   lane_base = 2'b00;
        endcase
    endfunction

    function automatic logic misaligned(access_size_t size, logic [1:0] offset);
        case (size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = offset[0];           // Odd half offset
            SIZE_WORD: misaligned = (offset != 2'b00);
            default:   misaligned = 1'b1;                // Unused size code
        endcase
    endfunction

endpackage

`default_nettype wire

// File: data_port_if.sv
`default_nettype none

interface data_port_if #(
    parameter int RAM_AW = 10
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    // Latched request fields, from the sequencer
    addr_t        op_addr;
    access_size_t op_size;
    logic         op_sign;      // Sign extend on load
    word_t        op_wdata;
    logic         op_store;     // 1 store, 0 load
    logic         strobe;       // One cycle, performs the access

    // Decode results
    logic [RAM_AW-1:0] word_idx;
    lane_en_t          lane_en;
    word_t             lane_wdata;
    region_t           region;

    word_t rdata;   // Registered RAM read

    modport seq (
        output op_addr, op_size, op_sign, op_wdata, op_store, strobe,
        input  region
    );

    modport decode (
        input  op_addr, op_size, op_wdata,
        output word_idx, lane_en, lane_wdata, region
    );

    modport ram (
        input  strobe, op_store, word_idx, lane_en, lane_wdata,
        output rdata
    );

    modport ret (
        input strobe, op_store, op_addr, op_size, op_sign, region, rdata
    );

endinterface

`default_nettype wire

// File: wait_state_timer.sv
`default_nettype none

module wait_state_timer #(
    parameter int WAIT_STATES = 2
) (
    input  wire logic MEM_CLK,
    input  wire logic rst_n,
    input  wire logic start,
    output logic      done    // One cycle at zero
);

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [CNT_W-1:0] count;
    logic             busy;

    always_ff @(posedge MEM_CLK) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CNT_W'(WAIT_STATES);   // Reload
        end else if (busy) begin
            if (count == '0)
                busy <= 1'b0;               // done seen, stop
            else
                count <= count - 1'b1;
        end
    end

    assign done = busy && (count == '0);

endmodule

`default_nettype wire

// File: access_decode.sv
`default_nettype none

module access_decode #(
    parameter int RAM_AW = 10
) (
    data_port_if.decode dp
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic [1:0] offset;          // Byte within word
    logic       in_io;
    logic       out_of_range;    // Above last RAM word
    lane_en_t   size_mask;

    assign offset       = dp.op_addr[1:0];
    assign in_io        = (dp.op_addr >= IO_BASE);
    assign out_of_range = (dp.op_addr[ADDR_W-1:RAM_AW+2] != '0);
    assign dp.word_idx  = dp.op_addr[RAM_AW+1:2];

    // I/O checked first, no alignment rule there
    always_comb begin
        if (in_io)
            dp.region = REGION_IO;
        else if (out_of_range || misaligned(dp.op_size, offset))
            dp.region = REGION_BAD;
        else
            dp.region = REGION_RAM;
    end

    //////////////////////////////////////////////////
    // Lane enables and store data
    //////////////////////////////////////////////////
    always_comb begin
        case (dp.op_size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            SIZE_WORD: size_mask = 4'b1111;
            default:   size_mask = 4'b0000;
        endcase
    end

    // RAM sees no lanes outside its region
    assign dp.lane_en = (dp.region == REGION_RAM) ?
                        lane_en_t'(size_mask << lane_base(dp.op_size, offset)) : '0;

    always_comb begin
        case (dp.op_size)
            SIZE_BYTE: dp.lane_wdata = {NUM_LANES{dp.op_wdata[LANE_W-1:0]}};      // Every lane
            SIZE_HALF: dp.lane_wdata = {(NUM_LANES/2){dp.op_wdata[2*LANE_W-1:0]}};
            default:   dp.lane_wdata = dp.op_wdata;
        endcase
    end

endmodule

`default_nettype wire

// File: byte_lane_ram.sv
`default_nettype none

module byte_lane_ram #(
    parameter int RAM_AW = 10
) (
    input  wire logic               MEM_CLK,
    input  wire logic               fetch_en,
    input  wire mem_map_pkg::addr_t fetch_addr,
    output mem_map_pkg::word_t      fetch_data,
    data_port_if.ram                dp
);
    import mem_map_pkg::*;

    word_t mem [0:2**RAM_AW-1];   // Contents undefined at start

    //////////////////////////////////////////////////
    // Fetch port, read only
    //////////////////////////////////////////////////
    always_ff @(posedge MEM_CLK) begin
        if (fetch_en)
            fetch_data <= mem[fetch_addr[RAM_AW+1:2]];   // Holds when idle
    end

    //////////////////////////////////////////////////
    // Data port
    //////////////////////////////////////////////////
    always_ff @(posedge MEM_CLK) begin
        if (dp.strobe && dp.op_store) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (dp.lane_en[i])
                    mem[dp.word_idx][i*LANE_W +: LANE_W] <= dp.lane_wdata[i*LANE_W +: LANE_W];
            end
        end
        if (dp.strobe && !dp.op_store)
            dp.rdata <= mem[dp.word_idx];   // Whole word, sliced later
    end

endmodule

`default_nettype wire

// File: load_return.sv
`default_nettype none

module load_return (
    input  wire logic               MEM_CLK,
    input  wire logic               rst_n,
    input  wire mem_map_pkg::word_t io_in,
    output mem_map_pkg::word_t      ld_data,
    data_port_if.ret                dp
);
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic                ld_strobe;
    region_t             region_q;    // Region of last load
    access_size_t        size_q;
    logic                sign_q;
    logic [1:0]          base_q;      // Lowest lane of last load
    word_t               io_sample;
    word_t               src_word;
    logic [LANE_W-1:0]   byte_sel;
    logic [2*LANE_W-1:0] half_sel;

    assign ld_strobe = dp.strobe && !dp.op_store;

    // Reads zero until the first load
    always_ff @(posedge MEM_CLK) begin
        if (!rst_n)
            region_q <= REGION_BAD;
        else if (ld_strobe)
            region_q <= dp.region;
    end

    // Latched with the RAM read, held to next load
    always_ff @(posedge MEM_CLK) begin
        if (ld_strobe) begin
            size_q <= dp.op_size;
            sign_q <= dp.op_sign;
            base_q <= lane_base(dp.op_size, dp.op_addr[1:0]);
            if (dp.region == REGION_IO)
                io_sample <= io_in;
        end
    end

    //////////////////////////////////////////////////
    // Slice and extend
    //////////////////////////////////////////////////
    assign src_word = (region_q == REGION_IO) ? io_sample : dp.rdata;
    assign byte_sel = src_word[base_q*LANE_W +: LANE_W];
    assign half_sel = src_word[base_q[1]*2*LANE_W +: 2*LANE_W];   // Lane 0 or 2

    always_comb begin
        if (region_q == REGION_BAD) begin
            ld_data = '0;
        end else begin
            case (size_q)
                SIZE_BYTE: ld_data = {{(WORD_W-LANE_W){sign_q && byte_sel[LANE_W-1]}}, byte_sel};
                SIZE_HALF: ld_data = {{(WORD_W-2*LANE_W){sign_q && half_sel[2*LANE_W-1]}},
                                      half_sel};
                default:   ld_data = src_word;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: access_sequencer.sv
`default_nettype none

module access_sequencer #(
    parameter int WAIT_STATES = 2
) (
    input  wire logic                         MEM_CLK,
    input  wire logic                         rst_n,
    input  wire logic                         ld_req,
    input  wire mem_map_pkg::addr_t           ld_addr,
    input  wire mem_access_pkg::access_size_t ld_size,
    input  wire logic                         ld_sign,
    input  wire logic                         st_req,
    input  wire mem_map_pkg::addr_t           st_addr,
    input  wire mem_access_pkg::access_size_t st_size,
    input  wire mem_map_pkg::word_t           st_wdata,
    output logic                              ld_ack,
    output logic                              st_ack,
    output logic                              ld_err,
    output logic                              st_err,
    output logic                              io_wr,      // One cycle per I/O store
    output mem_map_pkg::word_t                io_wdata,
    output logic                              timer_start,
    input  wire logic                         timer_done,
    data_port_if.seq                          dp
);
    import mem_access_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,      // Waiting for a req
        ST_WAIT,      // Wait states running
        ST_STROBE,    // Access performed this cycle
        ST_ACK,       // ack high until req drops
        ST_RELEASE    // ack low, one gap cycle
    } state_t;

    state_t state;
    logic   accept;      // Request taken this cycle
    logic   wait_over;
    logic   req_held;    // req of the port being served
    logic   bad;

    assign accept      = (state == ST_IDLE) && (ld_req || st_req);
    assign timer_start = accept;
    assign wait_over   = (WAIT_STATES == 0) || timer_done;   // No wait states, strobe next
    assign req_held    = dp.op_store ? st_req : ld_req;
    assign bad         = (dp.region == REGION_BAD);
    assign dp.strobe   = (state == ST_STROBE);

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////
    always_ff @(posedge MEM_CLK) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            ld_ack <= 1'b0;
            st_ack <= 1'b0;
            ld_err <= 1'b0;
            st_err <= 1'b0;
            io_wr  <= 1'b0;
        end else begin
            io_wr <= 1'b0;   // Pulse only
            case (state)
                ST_IDLE:    if (accept) state <= ST_WAIT;
                ST_WAIT:    if (wait_over) state <= ST_STROBE;
                ST_STROBE: begin
                    state <= ST_ACK;
                    if (dp.op_store) begin
                        st_ack <= 1'b1;
                        st_err <= bad;
                        io_wr  <= (dp.region == REGION_IO);
                    end else begin
                        ld_ack <= 1'b1;
                        ld_err <= bad;
                    end
                end
                ST_ACK: begin
                    // Other port waits while this req is held
                    if (!req_held) begin
                        ld_ack <= 1'b0;
                        st_ack <= 1'b0;
                        ld_err <= 1'b0;
                        st_err <= 1'b0;
                        state  <= ST_RELEASE;
                    end
                end
                ST_RELEASE: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Request fields, load wins
    //////////////////////////////////////////////////
    always_ff @(posedge MEM_CLK) begin
        if (accept) begin
            dp.op_store <= !ld_req;
            dp.op_addr  <= ld_req ? ld_addr : st_addr;
            dp.op_size  <= ld_req ? ld_size : st_size;
            dp.op_sign  <= ld_req && ld_sign;   // Stores never extend
            dp.op_wdata <= st_wdata;            // Ignored on loads
        end
        if (dp.strobe && dp.op_store && (dp.region == REGION_IO))
            io_wdata <= dp.op_wdata;            // Valid with io_wr
    end

endmodule

`default_nettype wire

// File: otter_mem.sv
`default_nettype none

module otter_mem #(
    parameter int RAM_AW      = 10,   // 1024 words
    parameter int WAIT_STATES = 2     // Extra cycles per data access
) (
    input  wire logic                         MEM_CLK,
    input  wire logic                         rst_n,
    // Instruction fetch
    input  wire logic                         fetch_en,
    input  wire mem_map_pkg::addr_t           fetch_addr,
    output mem_map_pkg::word_t                fetch_data,
    // Load port
    input  wire logic                         ld_req,
    input  wire mem_map_pkg::addr_t           ld_addr,
    input  wire mem_access_pkg::access_size_t ld_size,
    input  wire logic                         ld_sign,
    output logic                              ld_ack,
    output mem_map_pkg::word_t                ld_data,
    output logic                              ld_err,
    // Store port
    input  wire logic                         st_req,
    input  wire mem_map_pkg::addr_t           st_addr,
    input  wire mem_access_pkg::access_size_t st_size,
    input  wire mem_map_pkg::word_t           st_wdata,
    output logic                              st_ack,
    output logic                              st_err,
    // I/O
    input  wire mem_map_pkg::word_t           io_in,
    output logic                              io_wr,
    output mem_map_pkg::word_t                io_wdata
);

    logic timer_start;   // Sequencer accepts a request
    logic timer_done;    // Wait states elapsed

    data_port_if #(.RAM_AW(RAM_AW)) dp ();

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////
    access_sequencer #(.WAIT_STATES(WAIT_STATES)) u_access_sequencer (
        .MEM_CLK     (MEM_CLK),
        .rst_n       (rst_n),
        .ld_req      (ld_req),
        .ld_addr     (ld_addr),
        .ld_size     (ld_size),
        .ld_sign     (ld_sign),
        .st_req      (st_req),
        .st_addr     (st_addr),
        .st_size     (st_size),
        .st_wdata    (st_wdata),
        .ld_ack      (ld_ack),
        .st_ack      (st_ack),
        .ld_err      (ld_err),
        .st_err      (st_err),
        .io_wr       (io_wr),
        .io_wdata    (io_wdata),
        .timer_start (timer_start),
        .timer_done  (timer_done),
        .dp          (dp.seq)
    );

    wait_state_timer #(.WAIT_STATES(WAIT_STATES)) u_wait_state_timer (
        .MEM_CLK (MEM_CLK),
        .rst_n   (rst_n),
        .start   (timer_start),
        .done    (timer_done)
    );

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////
    access_decode #(.RAM_AW(RAM_AW)) u_access_decode (
        .dp (dp.decode)
    );

    byte_lane_ram #(.RAM_AW(RAM_AW)) u_byte_lane_ram (
        .MEM_CLK    (MEM_CLK),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .dp         (dp.ram)
    );

    load_return u_load_return (
        .MEM_CLK (MEM_CLK),
        .rst_n   (rst_n),
        .io_in   (io_in),
        .ld_data (ld_data),
        .dp      (dp.ret)
    );

endmodule

`default_nettype wire

// File: otter_mem_checks.svh
`ifndef OTTER_MEM_CHECKS_SVH
`define OTTER_MEM_CHECKS_SVH

//////////////////////////////////////////////////
// Test bookkeeping
//////////////////////////////////////////////////
int    error_count  = 0;   // Failed checks, whole run
int    tests_run    = 0;
int    tests_failed = 0;
int    test_id      = 0;   // Group number from pattern file
bit    test_ok      = 1'b1;

// Short name for each pattern group
function automatic string describe_test(input int num);
    case (num)
        0:       describe_test = "reset state";
        1:       describe_test = "word store/load/fetch";
        2:       describe_test = "lane merge and extend";
        3:       describe_test = "error accesses";
        4:       describe_test = "I/O region";
        5:       describe_test = "load/store arbitration";
        default: describe_test = "pattern group";
    endcase
endfunction

task automatic begin_test(input int num);
    test_id = num;
    test_ok = 1'b1;
    tests_run++;
endtask

task automatic finish_test();
    $display("Test %0d %-24s %s", test_id, describe_test(test_id), test_ok ? "ok" : "FAILED");
    if (!test_ok)
        tests_failed++;
endtask

//////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////
task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        error_count++;
        test_ok = 1'b0;
    end
endtask

// Failures that are not a wrong value
task automatic report_problem(input string what);
    $display("Problem at t=%0t: %s", $time, what);
    error_count++;
    test_ok = 1'b0;
endtask

task automatic report_counts();
    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
endtask

`endif

// File: otter_mem_tb.sv
`default_nettype none

module otter_mem_tb;
    import mem_map_pkg::*;
    import mem_access_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;   // Per wait loop

    logic         MEM_CLK;
    logic         rst_n;
    logic         fetch_en;
    addr_t        fetch_addr;
    word_t        fetch_data;
    logic         ld_req, ld_ack, ld_sign, ld_err;
    addr_t        ld_addr;
    access_size_t ld_size;
    word_t        ld_data;
    logic         st_req, st_ack, st_err;
    addr_t        st_addr;
    access_size_t st_size;
    word_t        st_wdata;
    word_t        io_in, io_wdata;
    logic         io_wr;

    integer seed;        // $random state
    bit     timed_out;   // Any wait loop ran out
    int     io_pulses;   // io_wr cycles seen so far
    word_t  io_seen;     // io_wdata at last pulse

    `include "otter_mem_checks.svh"

    otter_mem u_otter_mem (.*);

    initial begin
        MEM_CLK = 1'b0;
        forever #50 MEM_CLK = ~MEM_CLK;   // Period 100
    end

    // io_wr stable at the falling edge
    always @(negedge MEM_CLK) begin
        if (io_wr === 1'b1) begin
            io_pulses <= io_pulses + 1;
            io_seen   <= io_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Handshake tasks
    //////////////////////////////////////////////////
    task automatic wait_ack(input bit st_port, input logic level, input bit st_quiet,
                            input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = st_port ? st_ack : ld_ack;
        while (seen !== level && !timed_out) begin
            @(negedge MEM_CLK);
            cycles++;
            if (st_quiet)
                check_value("st_ack", {31'b0, st_ack}, 32'h0);   // Store held off
            if (cycles > TIMEOUT_CYCLES) begin
                report_problem($sformatf("%s never went to %0b", what, level));
                timed_out = 1'b1;
            end
            seen = st_port ? st_ack : ld_ack;
        end
    endtask

    task automatic hold_req();
        int hold;
        hold = $unsigned($random(seed)) % 4;   // 0 to 3 extra cycles
        repeat (hold) @(negedge MEM_CLK);
    endtask

    task automatic store_access(input addr_t addr, input int size, input word_t data,
                                output logic err, output int pulses);
        int base;
        base     = io_pulses;
        st_addr  = addr;
        st_size  = access_size_t'(size);
        st_wdata = data;
        st_req   = 1'b1;
        wait_ack(1'b1, 1'b1, 1'b0, "st_ack");
        err = st_err;
        hold_req();
        st_req = 1'b0;
        wait_ack(1'b1, 1'b0, 1'b0, "st_ack");
        pulses = io_pulses - base;
    endtask

    task automatic load_access(input addr_t addr, input int size, input logic sign,
                               input word_t io_val, output word_t word, output logic err);
        io_in   = io_val;   // Held through the access
        ld_addr = addr;
        ld_size = access_size_t'(size);
        ld_sign = sign;
        ld_req  = 1'b1;
        wait_ack(1'b0, 1'b1, 1'b0, "ld_ack");
        word = ld_data;
        err  = ld_err;
        hold_req();
        ld_req = 1'b0;
        wait_ack(1'b0, 1'b0, 1'b0, "ld_ack");
    endtask

    // Both reqs together, load must finish first
    task automatic pair_access(input addr_t addr, input int size, input logic sign,
                               input word_t data, output word_t word,
                               output logic ld_e, output logic st_e);
        ld_addr  = addr;
        ld_size  = access_size_t'(size);
        ld_sign  = sign;
        st_addr  = addr;
        st_size  = access_size_t'(size);
        st_wdata = data;
        ld_req   = 1'b1;
        st_req   = 1'b1;
        wait_ack(1'b0, 1'b1, 1'b1, "ld_ack");
        word = ld_data;
        ld_e = ld_err;
        hold_req();
        ld_req = 1'b0;
        wait_ack(1'b0, 1'b0, 1'b1, "ld_ack");
        wait_ack(1'b1, 1'b1, 1'b0, "st_ack");
        st_e = st_err;
        hold_req();
        st_req = 1'b0;
        wait_ack(1'b1, 1'b0, 1'b0, "st_ack");
    endtask

    task automatic fetch_word(input addr_t addr, output word_t word);
        fetch_addr = addr;
        fetch_en   = 1'b1;
        @(negedge MEM_CLK);   // Registered read, one cycle
        fetch_en = 1'b0;
        word = fetch_data;
    endtask

    //////////////////////////////////////////////////
    // One pattern line
    //////////////////////////////////////////////////
    task automatic run_line(input byte op, input addr_t addr, input int size, input int sign,
                            input word_t data, input word_t expected, input int exp_err);
        word_t got;
        logic  err, st_e;
        int    pulses;
        case (op)
            "S": begin
                store_access(addr, size, data, err, pulses);
                check_value("st_err", {31'b0, err}, word_t'(exp_err));
                check_value("io_wr pulses", word_t'(pulses), expected);
                if (expected == 1)
                    check_value("io_wdata", io_seen, data);
            end
            "L": begin
                load_access(addr, size, sign[0], data, got, err);
                check_value("ld_data", got, expected);
                check_value("ld_err", {31'b0, err}, word_t'(exp_err));
            end
            "F": begin
                fetch_word(addr, got);
                check_value("fetch_data", got, expected);
            end
            "P": begin
                pair_access(addr, size, sign[0], data, got, err, st_e);
                check_value("ld_data", got, expected);
                check_value("ld_err", {31'b0, err}, word_t'(exp_err));
                check_value("st_err", {31'b0, st_e}, word_t'(exp_err));
            end
            default: report_problem($sformatf("unknown operation %c in pattern file", op));
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        int    fields, test_num, cur_test, size, sign, exp_err;
        byte   op;
        addr_t addr;
        word_t data, expected;

        seed       = 92249;
        timed_out  = 1'b0;
        io_pulses  = 0;
        io_seen    = '0;
        rst_n      = 1'b0;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        ld_req     = 1'b0;
        ld_addr    = '0;
        ld_size    = SIZE_WORD;
        ld_sign    = 1'b0;
        st_req     = 1'b0;
        st_addr    = '0;
        st_size    = SIZE_WORD;
        st_wdata   = '0;
        io_in      = '0;

        repeat (8) @(negedge MEM_CLK);
        rst_n = 1'b1;

        begin_test(0);
        check_value("ld_ack", {31'b0, ld_ack}, 32'h0);
        check_value("st_ack", {31'b0, st_ack}, 32'h0);
        check_value("io_wr", {31'b0, io_wr}, 32'h0);
        check_value("ld_err", {31'b0, ld_err}, 32'h0);
        check_value("st_err", {31'b0, st_err}, 32'h0);
        finish_test();

        fd = $fopen("otter_mem_patterns.txt", "r");
        if (fd == 0)
            report_problem("pattern file otter_mem_patterns.txt could not be opened");
        cur_test = -1;
        while (fd != 0 && !$feof(fd) && !timed_out) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#")
                continue;   // Column notes
            fields = $sscanf(line, "%d %c %h %d %d %h %h %d",
                             test_num, op, addr, size, sign, data, expected, exp_err);
            if (fields != 8)
                continue;
            if (test_num != cur_test) begin
                if (cur_test >= 0)
                    finish_test();
                begin_test(test_num);
                cur_test = test_num;
            end
            run_line(op, addr, size, sign, data, expected, exp_err);
        end
        if (cur_test >= 0)
            finish_test();
        if (fd != 0)
            $fclose(fd);

        report_counts();
        if (error_count == 0 && !timed_out)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: otter_mem_patterns.txt
# test op addr size(0 byte,1 half,2 word) sign data expected err
# S expected = io_wr pulses, L data = io_in, F expected = fetch word, P load then store
1 S 00000000 2 0 12345678 00000000 0
1 S 00000004 2 0 cafef00d 00000000 0
1 S 00000ffc 2 0 a5a55a5a 00000000 0
1 L 00000000 2 0 00000000 12345678 0
1 L 00000004 2 0 00000000 cafef00d 0
1 L 00000ffc 2 0 00000000 a5a55a5a 0
1 F 00000000 2 0 00000000 12345678 0
1 F 00000ffc 2 0 00000000 a5a55a5a 0
2 S 00000010 2 0 00000000 00000000 0
2 S 00000011 0 0 000000ab 00000000 0
2 S 00000012 1 0 0000ff80 00000000 0
2 S 00000010 0 0 000000f7 00000000 0
2 L 00000010 2 0 00000000 ff80abf7 0
2 L 00000011 0 1 00000000 ffffffab 0
2 L 00000011 0 0 00000000 000000ab 0
2 L 00000012 1 1 00000000 ffffff80 0
2 L 00000012 1 0 00000000 0000ff80 0
2 L 00000010 1 1 00000000 ffffabf7 0
2 S 00000020 2 0 11223344 00000000 0
2 S 00000022 0 0 deadbe5c 00000000 0
2 L 00000022 1 1 00000000 0000115c 0
3 S 00000030 2 0 76543210 00000000 0
3 S 00000031 1 0 0000ffff 00000000 1
3 S 00000032 2 0 ffffffff 00000000 1
3 L 00000033 1 1 00000000 00000000 1
3 S 00001000 2 0 deadbeef 00000000 1
3 L 00001000 2 0 00000000 00000000 1
3 L 00000030 2 0 00000000 76543210 0
4 S 11000000 2 0 0000abcd 00000001 0
4 S 11000010 0 0 00000077 00000001 0
4 L 11000000 2 0 87654321 87654321 0
4 L 11000005 0 1 0000f000 fffffff0 0
4 L 11000006 1 0 9abc0000 00009abc 0
4 L 00000000 2 0 00000000 12345678 0
5 S 00000040 2 0 2468ace0 00000000 0
5 P 00000040 2 0 13579bdf 2468ace0 0
5 P 00000041 0 1 000000c3 ffffff9b 0
5 L 00000040 2 0 00000000 1357c3df 0

// File: otter_mem.f
+incdir+.
mem_map_pkg.sv
mem_access_pkg.sv
data_port_if.sv
wait_state_timer.sv
access_decode.sv
byte_lane_ram.sv
load_return.sv
access_sequencer.sv
otter_mem.sv
otter_mem_tb.sv
